// File: symb_rate_params.svh
/* Constants for the symbol rate selector. SR_SYMBOL_RATE_DIV is reported to software only
   and does not change the hold logic. */

`ifndef SYMB_RATE_PARAMS_SVH
`define SYMB_RATE_PARAMS_SVH

//////////////////////////////
// Identification

// Read back from the ID register, upper half
`define SR_MODULE_ID        16'h5352

// Read back from the ID register, lower half
`define SR_MODULE_VERSION   16'h0001

//////////////////////////////
// Rate and bus sizing

// DAC sample rate over full symbol rate
`define SR_SYMBOL_RATE_DIV  32'd8

// Avalon-MM byte address width
`define SR_ADDR_W           8

`endif

// File: symb_rate_pkg.sv
/* Types shared by the symbol rate selector. Select code 3 is reserved and never held
   in the rate register. */

`default_nettype none

package symb_rate_pkg;

    // Rate select encoding, code 3 reserved
    typedef enum logic [1:0] {
        SR_QUARTER = 2'd0,
        SR_HALF    = 2'd1,
        SR_FULL    = 2'd2
    } symb_rate_sel_t;

    // Register word indices
    localparam int SR_REG_SEL  = 0;
    localparam int SR_REG_DIV  = 1;
    localparam int SR_REG_ID   = 2;
    localparam int SR_NUM_REGS = 3;

    typedef struct packed {
        logic [29:0]    rsvd;
        symb_rate_sel_t code;
    } sel_view_t;

    typedef struct packed {
        logic [15:0] module_id;
        logic [15:0] version;
    } id_view_t;

    // One register word, read either as raw bits, as SEL or as ID
    typedef union packed {
        logic [31:0] raw;
        sel_view_t   sel;
        id_view_t    id;
    } reg_word_t;

    // Stream sample, Q in the upper half
    typedef struct packed {
        logic signed [15:0] q;
        logic signed [15:0] i;
    } sample_t;

endpackage

`default_nettype wire

// File: symb_rate_regs.sv
/* Avalon-MM slave without bursts, one command at a time. Read data and write responses
   come back exactly 1 cycle after acceptance. */

`timescale 1ns/1ps
`default_nettype none
`include "symb_rate_params.svh"

module symb_rate_regs (
    input  wire logic                           clk_ifc_avmm,
    input  wire logic                           rst_i,
    input  wire logic [`SR_ADDR_W-1:0]          avmm_address_i,
    input  wire logic                           avmm_read_i,
    input  wire logic                           avmm_write_i,
    input  wire logic [31:0]                    avmm_writedata_i,
    input  wire logic [3:0]                     avmm_byteenable_i,
    output logic                                avmm_waitrequest_o,
    output symb_rate_pkg::reg_word_t            avmm_readdata_o,
    output logic                                avmm_readdatavalid_o,
    output logic                                avmm_writeresponsevalid_o,
    output logic [1:0]                          avmm_response_o,
    output symb_rate_pkg::symb_rate_sel_t       rate_sel_o
);
    import symb_rate_pkg::*;

    localparam logic [1:0] RESP_OKAY        = 2'b00;
    localparam logic [1:0] RESP_SLAVE_ERROR = 2'b10;

    logic [`SR_ADDR_W-3:0] word_addr;
    logic                  rd_acc;
    logic                  wr_acc;
    logic                  addr_ok;
    logic [31:0]           lane_mask;
    reg_word_t             cur_word;
    reg_word_t             wr_word;
    reg_word_t             rd_word;

    //////////////////////////////
    // Address decode

    // Byte address to 32-bit word index
    assign word_addr = avmm_address_i[`SR_ADDR_W-1:2];
    assign addr_ok   = (word_addr < SR_NUM_REGS);

    assign rd_acc = avmm_read_i  && !avmm_waitrequest_o;
    assign wr_acc = avmm_write_i && !avmm_waitrequest_o;

    //////////////////////////////
    // Register word assembly

    // Current word at the addressed index, also the read data
    always_comb begin
        cur_word = '0;
        case (word_addr)
            SR_REG_SEL: cur_word.sel.code = rate_sel_o;
            SR_REG_DIV: cur_word.raw      = `SR_SYMBOL_RATE_DIV;
            SR_REG_ID: begin
                cur_word.id.module_id = `SR_MODULE_ID;
                cur_word.id.version   = `SR_MODULE_VERSION;
            end
            default:    cur_word.raw      = '0;
        endcase
    end

    assign rd_word = cur_word;

    // Expand byte enables into a bit mask
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            lane_mask[b*8 +: 8] = {8{avmm_byteenable_i[b]}};
        end
    end

    // Disabled lanes keep the old bits, so SEL only moves through lane 0
    assign wr_word.raw = (cur_word.raw & ~lane_mask) | (avmm_writedata_i & lane_mask);

    //////////////////////////////
    // Command handling

    always_ff @(posedge clk_ifc_avmm) begin
        if (rst_i) begin
            avmm_waitrequest_o        <= 1'b1;
            avmm_readdatavalid_o      <= 1'b0;
            avmm_writeresponsevalid_o <= 1'b0;
            rate_sel_o                <= SR_FULL;
        end else begin
            avmm_waitrequest_o        <= 1'b0;
            avmm_readdatavalid_o      <= rd_acc;
            avmm_writeresponsevalid_o <= wr_acc;

            // Only SEL is writable, reserved code rejected
            if (wr_acc && addr_ok && word_addr == SR_REG_SEL &&
                wr_word.sel.code != 2'd3) begin
                rate_sel_o <= wr_word.sel.code;
            end
        end
    end

    // Response payload
    always_ff @(posedge clk_ifc_avmm) begin
        if (wr_acc) begin
            if (!addr_ok) begin
                avmm_response_o <= RESP_SLAVE_ERROR;
            end else if (word_addr == SR_REG_SEL && wr_word.sel.code == 2'd3) begin
                avmm_response_o <= RESP_SLAVE_ERROR;
            end else begin
                avmm_response_o <= RESP_OKAY;
            end
        end
        if (rd_acc) begin
            avmm_readdata_o <= rd_word;
            avmm_response_o <= addr_ok ? RESP_OKAY : RESP_SLAVE_ERROR;
        end
    end

endmodule

`default_nettype wire

// File: symb_rate_hold.sv
/* Zero-order hold, one sample deep. The repeat factor is sampled at acceptance, so a rate
   change takes effect from the next sample on. */

`timescale 1ns/1ps
`default_nettype none

module symb_rate_hold (
    input  wire logic                           clk_ifc_avmm,
    input  wire logic                           rst_i,
    input  wire symb_rate_pkg::symb_rate_sel_t  rate_sel_i,
    input  wire logic                           in_valid_i,
    output logic                                in_ready_o,
    input  wire symb_rate_pkg::sample_t         in_data_i,
    output logic                                hold_valid_o,
    input  wire logic                           hold_ready_i,
    output symb_rate_pkg::sample_t              hold_data_o
);
    import symb_rate_pkg::*;

    // Copies still owed after the one on the bus
    logic [1:0] rpt_left;
    logic       in_fire;
    logic       copy_fire;
    logic       last_copy;

    //////////////////////////////
    // Repeat factor decode

    // Quarter rate gives 4 copies, half 2, full 1
    function automatic logic [1:0] extra_copies(input symb_rate_sel_t sel);
        logic [1:0] n;
        case (sel)
            SR_QUARTER: n = 2'd3;
            SR_HALF:    n = 2'd1;
            SR_FULL:    n = 2'd0;
            default:    n = 2'd0;
        endcase
        return n;
    endfunction

    //////////////////////////////
    // Handshake

    assign copy_fire = hold_valid_o && hold_ready_i;
    assign last_copy = copy_fire && (rpt_left == 2'd0);

    // Refill in the same cycle the last copy leaves
    assign in_ready_o = !hold_valid_o || last_copy;
    assign in_fire    = in_valid_i && in_ready_o;

    //////////////////////////////
    // Control state

    always_ff @(posedge clk_ifc_avmm) begin
        if (rst_i) begin
            hold_valid_o <= 1'b0;
            rpt_left     <= 2'd0;
        end else begin
            if (in_fire) begin
                hold_valid_o <= 1'b1;
                rpt_left     <= extra_copies(rate_sel_i);
            end else if (last_copy) begin
                hold_valid_o <= 1'b0;
            end else if (copy_fire) begin
                rpt_left     <= rpt_left - 2'd1;
            end
        end
    end

    // Held sample
    always_ff @(posedge clk_ifc_avmm) begin
        if (in_fire) begin
            hold_data_o <= in_data_i;
        end
    end

endmodule

`default_nettype wire

// File: symb_rate_out_buf.sv
/* Two-entry skid buffer, 1 cycle of latency when not stalled. Upstream ready comes
   from a flop only. */

`timescale 1ns/1ps
`default_nettype none

module symb_rate_out_buf (
    input  wire logic                       clk_ifc_avmm,
    input  wire logic                       rst_i,
    input  wire logic                       hold_valid_i,
    output logic                            hold_ready_o,
    input  wire symb_rate_pkg::sample_t     hold_data_i,
    output logic                            out_valid_o,
    input  wire logic                       out_ready_i,
    output symb_rate_pkg::sample_t          out_data_o
);
    import symb_rate_pkg::*;

    logic    spare_valid;
    sample_t spare_data;
    logic    in_fire;
    logic    main_free;

    // Accept only while the spare slot is empty
    assign hold_ready_o = !spare_valid;
    assign in_fire      = hold_valid_i && hold_ready_o;

    // Main entry empties or leaves this cycle
    assign main_free = !out_valid_o || out_ready_i;

    //////////////////////////////
    // Entry valids

    always_ff @(posedge clk_ifc_avmm) begin
        if (rst_i) begin
            out_valid_o <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_free) begin
            if (spare_valid) begin
                out_valid_o <= 1'b1;
                spare_valid <= 1'b0;
            end else begin
                out_valid_o <= in_fire;
            end
        end else if (in_fire) begin
            // Stalled, park the incoming item
            spare_valid <= 1'b1;
        end
    end

    //////////////////////////////
    // Entry data

    always_ff @(posedge clk_ifc_avmm) begin
        if (main_free) begin
            if (spare_valid) begin
                out_data_o <= spare_data;
            end else if (in_fire) begin
                out_data_o <= hold_data_i;
            end
        end else if (in_fire) begin
            spare_data <= hold_data_i;
        end
    end

endmodule

`default_nettype wire

// File: symb_rate_top.sv
/* Single clock domain, single synchronous reset. Input to first output copy takes
   2 cycles when the output is not stalled. */

`timescale 1ns/1ps
`default_nettype none
`include "symb_rate_params.svh"

module symb_rate_top (
    input  wire logic                       clk_ifc_avmm,
    input  wire logic                       rst_i,

    // Avalon-MM register port
    input  wire logic [`SR_ADDR_W-1:0]      avmm_address_i,
    input  wire logic                       avmm_read_i,
    input  wire logic                       avmm_write_i,
    input  wire logic [31:0]                avmm_writedata_i,
    input  wire logic [3:0]                 avmm_byteenable_i,
    output logic                            avmm_waitrequest_o,
    output symb_rate_pkg::reg_word_t        avmm_readdata_o,
    output logic                            avmm_readdatavalid_o,
    output logic                            avmm_writeresponsevalid_o,
    output logic [1:0]                      avmm_response_o,

    // Sample stream
    input  wire logic                       in_valid_i,
    output logic                            in_ready_o,
    input  wire symb_rate_pkg::sample_t     in_data_i,
    output logic                            out_valid_o,
    input  wire logic                       out_ready_i,
    output symb_rate_pkg::sample_t          out_data_o
);
    import symb_rate_pkg::*;

    symb_rate_sel_t rate_sel;
    logic           hold_valid;
    logic           hold_ready;
    sample_t        hold_data;

    //////////////////////////////
    // Register block

    symb_rate_regs regs_i (
        .clk_ifc_avmm              (clk_ifc_avmm),
        .rst_i                     (rst_i),
        .avmm_address_i            (avmm_address_i),
        .avmm_read_i               (avmm_read_i),
        .avmm_write_i              (avmm_write_i),
        .avmm_writedata_i          (avmm_writedata_i),
        .avmm_byteenable_i         (avmm_byteenable_i),
        .avmm_waitrequest_o        (avmm_waitrequest_o),
        .avmm_readdata_o           (avmm_readdata_o),
        .avmm_readdatavalid_o      (avmm_readdatavalid_o),
        .avmm_writeresponsevalid_o (avmm_writeresponsevalid_o),
        .avmm_response_o           (avmm_response_o),
        .rate_sel_o                (rate_sel)
    );

    //////////////////////////////
    // Stream path

    symb_rate_hold hold_i (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_i        (rst_i),
        .rate_sel_i   (rate_sel),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_data_i    (in_data_i),
        .hold_valid_o (hold_valid),
        .hold_ready_i (hold_ready),
        .hold_data_o  (hold_data)
    );

    // Registers the stream and cuts the ready path back to the hold
    symb_rate_out_buf out_buf_i (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_i        (rst_i),
        .hold_valid_i (hold_valid),
        .hold_ready_o (hold_ready),
        .hold_data_i  (hold_data),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_data_o   (out_data_o)
    );

endmodule

`default_nettype wire

// File: symb_rate_checker.sv
/* Protocol assertions for symb_rate_top, attached by bind. Response timing assumes the
   host issues one Avalon-MM command at a time. */

`timescale 1ns/1ps
`default_nettype none

module symb_rate_checker (
    input  wire logic        clk_ifc_avmm,
    input  wire logic        rst_i,
    input  wire logic        avmm_read_i,
    input  wire logic        avmm_write_i,
    input  wire logic        avmm_waitrequest_o,
    input  wire logic        avmm_readdatavalid_o,
    input  wire logic        avmm_writeresponsevalid_o,
    input  wire logic        out_valid_o,
    input  wire logic        out_ready_i,
    input  wire logic [31:0] out_data_o
);

    int fail_cnt = 0;

    // Read data valid exactly 1 cycle after an accepted read and never otherwise
    a_rd_resp: assert property (@(posedge clk_ifc_avmm) disable iff (rst_i)
        avmm_readdatavalid_o == $past(avmm_read_i && !avmm_waitrequest_o))
        else begin
            $error("read data valid not exactly 1 cycle after an accepted read");
            fail_cnt++;
        end

    // Same rule for write responses
    a_wr_resp: assert property (@(posedge clk_ifc_avmm) disable iff (rst_i)
        avmm_writeresponsevalid_o == $past(avmm_write_i && !avmm_waitrequest_o))
        else begin
            $error("write response valid not exactly 1 cycle after an accepted write");
            fail_cnt++;
        end

    // Stalled output holds its sample
    a_out_stable: assert property (@(posedge clk_ifc_avmm) disable iff (rst_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
        else begin
            $error("output sample dropped or changed while stalled");
            fail_cnt++;
        end

    a_reset_idle: assert property (@(posedge clk_ifc_avmm)
        rst_i |=> (!out_valid_o && !avmm_readdatavalid_o && !avmm_writeresponsevalid_o))
        else begin
            $error("valid output high right after reset");
            fail_cnt++;
        end

    // Waitrequest high during reset and low once reset is released
    a_wait_req: assert property (@(posedge clk_ifc_avmm)
        1'b1 |=> (avmm_waitrequest_o == $past(rst_i)))
        else begin
            $error("waitrequest does not follow reset");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: symb_rate_monitor.sv
/* Scoreboard for symb_rate_top, sampling on the falling edge. Assumes no rate write
   while samples are still in flight. */

`timescale 1ns/1ps
`default_nettype none
`include "symb_rate_params.svh"

module symb_rate_monitor (
    input  wire logic                       clk_ifc_avmm,
    input  wire logic                       rst_i,
    input  wire logic [`SR_ADDR_W-1:0]      avmm_address_i,
    input  wire logic                       avmm_write_i,
    input  wire logic                       avmm_waitrequest_i,
    input  wire logic [31:0]                avmm_writedata_i,
    input  wire logic [3:0]                 avmm_byteenable_i,
    input  wire logic [31:0]                avmm_readdata_i,
    input  wire logic                       avmm_readdatavalid_i,
    input  wire logic                       avmm_writeresponsevalid_i,
    input  wire logic [1:0]                 avmm_response_i,
    input  wire logic                       in_valid_i,
    input  wire logic                       in_ready_i,
    input  wire symb_rate_pkg::sample_t     in_data_i,
    input  wire logic                       out_valid_i,
    input  wire logic                       out_ready_i,
    input  wire symb_rate_pkg::sample_t     out_data_i,
    input  wire logic [1:0]                 exp_resp_i,
    input  wire logic [31:0]                exp_data_i,
    input  wire logic                       exp_data_chk_i,
    output int                              err_cnt_o,
    output int                              chk_cnt_o,
    output int                              pending_o
);
    import symb_rate_pkg::*;

    sample_t        exp_q[$];
    int             left_q[$];
    logic [1:0]     sel_model;
    int             err_cnt = 0;
    int             chk_cnt = 0;
    int             pending = 0;

    assign err_cnt_o = err_cnt;
    assign chk_cnt_o = chk_cnt;
    assign pending_o = pending;

    // Copies per sample: quarter 4, half 2, full 1
    function automatic int repeat_factor(input logic [1:0] code);
        case (code)
            2'd0:    return 4;
            2'd1:    return 2;
            default: return 1;
        endcase
    endfunction

    task automatic compare_value(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, sig, exp, act);
        end
    endtask

    always @(negedge clk_ifc_avmm) begin
        if (rst_i) begin
            sel_model = 2'd2;
            exp_q.delete();
            left_q.delete();
        end else begin
            // A sample accepted now cannot leave in the same cycle
            if (out_valid_i && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("Output sample %h at %0t ns arrived with no input pending",
                             out_data_i, $time);
                end else begin
                    compare_value("out_data_o", exp_q[0], out_data_i);
                    left_q[0] = left_q[0] - 1;
                    if (left_q[0] == 0) begin
                        void'(exp_q.pop_front());
                        void'(left_q.pop_front());
                    end
                end
            end
            // Factor taken before a write in this cycle can move it
            if (in_valid_i && in_ready_i) begin
                exp_q.push_back(in_data_i);
                left_q.push_back(repeat_factor(sel_model));
            end
            if (avmm_write_i && !avmm_waitrequest_i &&
                avmm_address_i[`SR_ADDR_W-1:2] == SR_REG_SEL &&
                avmm_byteenable_i[0] && avmm_writedata_i[1:0] != 2'd3) begin
                sel_model = avmm_writedata_i[1:0];
            end
            if (avmm_readdatavalid_i) begin
                compare_value("avmm_response_o", exp_resp_i, avmm_response_i);
                if (exp_data_chk_i) begin
                    compare_value("avmm_readdata_o", exp_data_i, avmm_readdata_i);
                end
            end
            if (avmm_writeresponsevalid_i) begin
                compare_value("avmm_response_o", exp_resp_i, avmm_response_i);
            end
        end
        pending = exp_q.size();
    end

endmodule

`default_nettype wire

// File: tb_symb_rate.sv
/* Table-driven testbench for symb_rate_top. Rate writes are issued only after the
   stream has drained, and back-pressure comes from $random. */

`timescale 1ns/1ps
`default_nettype none
`include "symb_rate_params.svh"

module tb_symb_rate;
    import symb_rate_pkg::*;

    typedef enum {OP_RD, OP_WR, OP_BURST} op_t;

    typedef struct {
        op_t         op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic [1:0]  resp;
        logic [31:0] rdata;
        int          count;
    } row_t;

    localparam logic [1:0]  OKAY   = 2'b00;
    localparam logic [1:0]  SLVERR = 2'b10;
    localparam logic [31:0] ID_WORD = {`SR_MODULE_ID, `SR_MODULE_VERSION};

    logic                  clk_ifc_avmm;
    logic                  rst;
    logic [`SR_ADDR_W-1:0] avmm_address;
    logic                  avmm_read;
    logic                  avmm_write;
    logic [31:0]           avmm_writedata;
    logic [3:0]            avmm_byteenable;
    logic                  avmm_waitrequest;
    reg_word_t             avmm_readdata;
    logic                  avmm_readdatavalid;
    logic                  avmm_writeresponsevalid;
    logic [1:0]            avmm_response;
    logic                  in_valid;
    logic                  in_ready;
    sample_t               in_data;
    logic                  out_valid;
    logic                  out_ready;
    sample_t               out_data;
    logic [1:0]            exp_resp;
    logic [31:0]           exp_data;
    logic                  exp_data_chk;
    int                    err_cnt;
    int                    chk_cnt;
    int                    pending;
    row_t                  rows[$];
    integer                seed;
    int                    wd_cycles = 0;

    symb_rate_top dut_i (
        .clk_ifc_avmm(clk_ifc_avmm), .rst_i(rst),
        .avmm_address_i(avmm_address), .avmm_read_i(avmm_read),
        .avmm_write_i(avmm_write), .avmm_writedata_i(avmm_writedata),
        .avmm_byteenable_i(avmm_byteenable), .avmm_waitrequest_o(avmm_waitrequest),
        .avmm_readdata_o(avmm_readdata), .avmm_readdatavalid_o(avmm_readdatavalid),
        .avmm_writeresponsevalid_o(avmm_writeresponsevalid),
        .avmm_response_o(avmm_response),
        .in_valid_i(in_valid), .in_ready_o(in_ready), .in_data_i(in_data),
        .out_valid_o(out_valid), .out_ready_i(out_ready), .out_data_o(out_data)
    );

    symb_rate_monitor monitor_i (
        .clk_ifc_avmm(clk_ifc_avmm), .rst_i(rst),
        .avmm_address_i(avmm_address), .avmm_write_i(avmm_write),
        .avmm_waitrequest_i(avmm_waitrequest), .avmm_writedata_i(avmm_writedata),
        .avmm_byteenable_i(avmm_byteenable), .avmm_readdata_i(avmm_readdata),
        .avmm_readdatavalid_i(avmm_readdatavalid),
        .avmm_writeresponsevalid_i(avmm_writeresponsevalid),
        .avmm_response_i(avmm_response),
        .in_valid_i(in_valid), .in_ready_i(in_ready), .in_data_i(in_data),
        .out_valid_i(out_valid), .out_ready_i(out_ready), .out_data_i(out_data),
        .exp_resp_i(exp_resp), .exp_data_i(exp_data), .exp_data_chk_i(exp_data_chk),
        .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt), .pending_o(pending)
    );

    bind symb_rate_top symb_rate_checker checker_i (
        .clk_ifc_avmm(clk_ifc_avmm), .rst_i(rst_i), .avmm_read_i(avmm_read_i),
        .avmm_write_i(avmm_write_i), .avmm_waitrequest_o(avmm_waitrequest_o),
        .avmm_readdatavalid_o(avmm_readdatavalid_o),
        .avmm_writeresponsevalid_o(avmm_writeresponsevalid_o),
        .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .out_data_o(out_data_o)
    );

    always #5 clk_ifc_avmm = ~clk_ifc_avmm;

    // Random back-pressure with ready about 3 cycles in 4
    always @(posedge clk_ifc_avmm) begin
        #1;
        out_ready = (($random(seed) & 3) != 0);
    end

    function automatic void append_row(input op_t op, input logic [7:0] addr,
                                       input logic [31:0] data, input logic [3:0] be,
                                       input logic [1:0] resp, input logic [31:0] rdata,
                                       input int count);
        row_t r;
        r = '{op, addr, data, be, resp, rdata, count};
        rows.push_back(r);
    endfunction

    task automatic bus_access(input row_t r);
        avmm_address    = r.addr;
        avmm_writedata  = r.data;
        avmm_byteenable = r.be;
        avmm_read       = (r.op == OP_RD);
        avmm_write      = (r.op == OP_WR);
        exp_resp        = r.resp;
        exp_data        = r.rdata;
        exp_data_chk    = (r.op == OP_RD) && (r.resp == OKAY);
        @(negedge clk_ifc_avmm);
        while (avmm_waitrequest) @(negedge clk_ifc_avmm);
        @(posedge clk_ifc_avmm);
        #1;
        avmm_read  = 1'b0;
        avmm_write = 1'b0;
        @(negedge clk_ifc_avmm);
        while (!(avmm_readdatavalid || avmm_writeresponsevalid)) @(negedge clk_ifc_avmm);
        @(posedge clk_ifc_avmm);
        #1;
    endtask

    // Q carries the row index and I the sample index
    task automatic send_burst(input int count, input int row_idx);
        for (int k = 0; k < count; k++) begin
            in_valid = 1'b1;
            in_data  = {16'(row_idx), 16'(k)};
            @(negedge clk_ifc_avmm);
            while (!in_ready) @(negedge clk_ifc_avmm);
            @(posedge clk_ifc_avmm);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic drain_stream();
        while (pending != 0) begin
            @(posedge clk_ifc_avmm);
            #1;
        end
    endtask

    initial begin
        int max_burst;
        int total;
        int asrt_fails;
        clk_ifc_avmm = 1'b0;
        rst = 1'b1;
        seed = 32'h8d95_b9b9;
        avmm_address = '0;
        avmm_read = 1'b0;
        avmm_write = 1'b0;
        avmm_writedata = '0;
        avmm_byteenable = '0;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b0;
        exp_resp = OKAY;
        exp_data = '0;
        exp_data_chk = 1'b0;

        //////////////////////////////
        // Stimulus table
        append_row(OP_RD, 8'h00, 0, 4'hf, OKAY, 32'd2, 0);
        append_row(OP_RD, 8'h04, 0, 4'hf, OKAY, `SR_SYMBOL_RATE_DIV, 0);
        append_row(OP_RD, 8'h08, 0, 4'hf, OKAY, ID_WORD, 0);
        append_row(OP_BURST, 0, 0, 0, OKAY, 0, 6);
        append_row(OP_WR, 8'h00, 32'd0, 4'hf, OKAY, 0, 0);
        append_row(OP_RD, 8'h00, 0, 4'hf, OKAY, 32'd0, 0);
        append_row(OP_BURST, 0, 0, 0, OKAY, 0, 6);
        append_row(OP_WR, 8'h00, 32'd1, 4'hf, OKAY, 0, 0);
        append_row(OP_BURST, 0, 0, 0, OKAY, 0, 8);
        append_row(OP_WR, 8'h00, 32'd3, 4'hf, SLVERR, 0, 0);
        append_row(OP_RD, 8'h00, 0, 4'hf, OKAY, 32'd1, 0);
        // Lane 0 off so SEL must not move
        append_row(OP_WR, 8'h00, 32'd2, 4'he, OKAY, 0, 0);
        append_row(OP_RD, 8'h00, 0, 4'hf, OKAY, 32'd1, 0);
        append_row(OP_WR, 8'h0c, 32'd0, 4'hf, SLVERR, 0, 0);
        append_row(OP_RD, 8'h0c, 0, 4'hf, SLVERR, 0, 0);
        append_row(OP_RD, 8'hfc, 0, 4'hf, SLVERR, 0, 0);
        append_row(OP_WR, 8'h04, 32'hffff, 4'hf, OKAY, 0, 0);
        append_row(OP_RD, 8'h04, 0, 4'hf, OKAY, `SR_SYMBOL_RATE_DIV, 0);
        append_row(OP_WR, 8'h08, 32'd0, 4'hf, OKAY, 0, 0);
        append_row(OP_RD, 8'h08, 0, 4'hf, OKAY, ID_WORD, 0);
        append_row(OP_RD, 8'h00, 0, 4'hf, OKAY, 32'd1, 0);
        append_row(OP_WR, 8'h00, 32'd2, 4'hf, OKAY, 0, 0);
        append_row(OP_RD, 8'h00, 0, 4'hf, OKAY, 32'd2, 0);
        append_row(OP_BURST, 0, 0, 0, OKAY, 0, 8);
        append_row(OP_WR, 8'h00, 32'd0, 4'h1, OKAY, 0, 0);
        append_row(OP_BURST, 0, 0, 0, OKAY, 0, 5);

        max_burst = 1;
        foreach (rows[n]) begin
            if (rows[n].count > max_burst) begin
                max_burst = rows[n].count;
            end
        end
        wd_cycles = rows.size() * 4 * max_burst + 200;

        repeat (3) @(posedge clk_ifc_avmm);
        #1;
        rst = 1'b0;

        foreach (rows[n]) begin
            if (rows[n].op == OP_BURST) begin
                send_burst(rows[n].count, n);
                drain_stream();
            end else begin
                bus_access(rows[n]);
            end
        end
        repeat (10) @(posedge clk_ifc_avmm);

        asrt_fails = dut_i.checker_i.fail_cnt;
        total = err_cnt + asrt_fails;
        if (out_valid) begin
            $display("Output still valid after all samples were consumed");
            total++;
        end
        $display("Checks: %0d, errors: %0d, assertion failures among them: %0d",
                 chk_cnt, total, asrt_fails);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk_ifc_avmm);
        $display("Timeout: the run did not finish within %0d cycles", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
symb_rate_pkg.sv
symb_rate_regs.sv
symb_rate_hold.sv
symb_rate_out_buf.sv
symb_rate_top.sv
symb_rate_checker.sv
symb_rate_monitor.sv
tb_symb_rate.sv
